//--- mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

    typedef logic [31:0] word_t;      // data word or instruction word
    typedef logic [4:0]  reg_addr_t;  // register number
    typedef logic [5:0]  opcode_t;    // instr[31:26]
    typedef logic [5:0]  funct_t;     // instr[5:0] of an R-type
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  jump_type_t;

    // opcodes of the supported subset
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // function field values under OP_RTYPE
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4; // signed compare, result is 0 or 1

    // what a decode-resolved transfer reads from the register file
    localparam jump_type_t JT_NONE = 2'd0; // no transfer, or j which reads nothing
    localparam jump_type_t JT_CMP  = 2'd1; // beq and bne read rs and rt
    localparam jump_type_t JT_REG  = 2'd2; // jr reads rs only

endpackage

`default_nettype wire

//--- mips_pipe_if.sv
`timescale 1ns/100ps
`default_nettype none

// decode to execute register
interface id_ex_if;
    logic                    valid;
    mips_pipe_pkg::alu_op_t   alu_op;
    mips_pipe_pkg::word_t     rs_val;   // register file value, before forwarding
    mips_pipe_pkg::word_t     rt_val;
    mips_pipe_pkg::reg_addr_t rs;
    mips_pipe_pkg::reg_addr_t rt;
    mips_pipe_pkg::word_t     imm;      // already sign extended
    logic                    use_imm;
    logic                    memread;
    logic                    memwrite;
    logic                    regwrite;
    mips_pipe_pkg::reg_addr_t rd;       // rt for I-type

    modport source (output valid, alu_op, rs_val, rt_val, rs, rt, imm, use_imm,
                    memread, memwrite, regwrite, rd);
    modport sink   (input valid, alu_op, rs_val, rt_val, rs, rt, imm, use_imm,
                    memread, memwrite, regwrite, rd);
endinterface

// execute to memory register
interface ex_mem_if;
    logic                    valid;
    mips_pipe_pkg::word_t     alu_result; // also the load or store address
    mips_pipe_pkg::word_t     store_data; // forwarded rt value
    logic                    memread;
    logic                    memwrite;
    logic                    regwrite;
    mips_pipe_pkg::reg_addr_t rd;

    modport source (output valid, alu_result, store_data, memread, memwrite, regwrite, rd);
    modport sink   (input valid, alu_result, store_data, memread, memwrite, regwrite, rd);
endinterface

// memory to write-back register, result already selected
interface mem_wb_if;
    logic                    valid;
    logic                    regwrite;
    mips_pipe_pkg::reg_addr_t rd;
    mips_pipe_pkg::word_t     result;

    modport source (output valid, regwrite, rd, result);
    modport sink   (input valid, regwrite, rd, result);
endinterface

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  wire                  i_stall,   // hold pc and the decode register
    input  wire                  i_take,    // transfer resolved in decode
    input  mips_pipe_pkg::word_t i_target,
    input  mips_pipe_pkg::word_t i_instr,   // instruction memory answer for o_pc
    output mips_pipe_pkg::word_t o_pc,
    output mips_pipe_pkg::word_t o_if_instr,
    output mips_pipe_pkg::word_t o_if_pc4,
    output logic                 o_if_squash
);

    mips_pipe_pkg::word_t pc_plus4;

    assign pc_plus4 = o_pc + 32'd4;

    // control state, squash comes out of reset set so decode sees an empty slot
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc        <= '0;
            o_if_squash <= 1'b1;
        end else if (!i_stall) begin
            o_pc        <= i_take ? i_target : pc_plus4;
            o_if_squash <= i_take; // the word fetched now sits behind the transfer
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_if_instr <= i_instr;
            o_if_pc4   <= pc_plus4; // base for the branch target in decode
        end
    end

    // branch offsets and jump targets are word multiples, so pc never loses alignment
    a_pc_aligned : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hazard_detection_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detection_unit (
    input  wire                       i_memread_ex,   // load sitting in execute
    input  mips_pipe_pkg::reg_addr_t  i_rt_ex,        // its destination
    input  mips_pipe_pkg::reg_addr_t  i_rs_id,
    input  mips_pipe_pkg::reg_addr_t  i_rt_id,
    input  mips_pipe_pkg::jump_type_t i_jumptype,     // transfer in decode
    input  mips_pipe_pkg::reg_addr_t  i_rd_ex,
    input  mips_pipe_pkg::reg_addr_t  i_rd_mem,
    input  wire                       i_regwrite_ex,
    input  wire                       i_regwrite_mem,
    output logic                      o_stall
);

    logic load_use;
    logic rs_busy; // rs still being produced in execute or memory
    logic rt_busy;

    // a load result is only ready at the end of memory, so the consumer waits one cycle
    assign load_use = i_memread_ex && (i_rt_ex != '0) &&
                      ((i_rt_ex == i_rs_id) || (i_rt_ex == i_rt_id));

    // write-back needs no term here because the register file reads through the write
    assign rs_busy = (i_rs_id != '0) &&
                     ((i_regwrite_ex && (i_rd_ex == i_rs_id)) ||
                      (i_regwrite_mem && (i_rd_mem == i_rs_id)));
    assign rt_busy = (i_rt_id != '0) &&
                     ((i_regwrite_ex && (i_rd_ex == i_rt_id)) ||
                      (i_regwrite_mem && (i_rd_mem == i_rt_id)));

    always_comb begin
        case (i_jumptype)
            mips_pipe_pkg::JT_CMP: o_stall = load_use || rs_busy || rt_busy; // beq, bne
            mips_pipe_pkg::JT_REG: o_stall = load_use || rs_busy;            // jr
            default:               o_stall = load_use;
        endcase
    end

    // a load in execute is also the register writer that the branch terms see there
    always_comb begin
        if (i_memread_ex) begin
            a_load_is_writer : assert (i_regwrite_ex && (i_rd_ex == i_rt_ex));
        end
    end

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  mips_pipe_pkg::word_t     i_if_instr,
    input  mips_pipe_pkg::word_t     i_if_pc4,
    input  wire                      i_if_squash,
    input  mips_pipe_pkg::reg_addr_t i_ex_rd,        // instruction now in execute
    input  wire                      i_ex_regwrite,
    input  mips_pipe_pkg::reg_addr_t i_mem_rd,       // instruction now in memory
    input  wire                      i_mem_regwrite,
    mem_wb_if.sink                   wb,
    id_ex_if.source                  idex,
    output logic                     o_stall,
    output logic                     o_take,
    output mips_pipe_pkg::word_t     o_target
);

    mips_pipe_pkg::word_t      rf [32];
    mips_pipe_pkg::opcode_t    opcode;
    mips_pipe_pkg::funct_t     funct;
    mips_pipe_pkg::reg_addr_t  rs, rt, dest;
    mips_pipe_pkg::word_t      simm, rs_val, rt_val, br_target, j_target;
    mips_pipe_pkg::alu_op_t    alu_op;
    mips_pipe_pkg::jump_type_t jtype;
    logic valid, use_imm, memread, memwrite, regwrite, is_j, is_bne, cmp_hit, wb_we;

    assign valid  = !i_if_squash;
    assign opcode = i_if_instr[31:26];
    assign funct  = i_if_instr[5:0];
    assign rs     = i_if_instr[25:21];
    assign rt     = i_if_instr[20:16];
    assign simm   = {{16{i_if_instr[15]}}, i_if_instr[15:0]};

    always_comb begin
        alu_op   = mips_pipe_pkg::ALU_ADD; // address math for lw and sw
        use_imm  = 1'b0;
        memread  = 1'b0;
        memwrite = 1'b0;
        regwrite = 1'b0;
        dest     = i_if_instr[15:11];
        jtype    = mips_pipe_pkg::JT_NONE;
        is_j     = 1'b0;
        is_bne   = 1'b0;
        case (opcode)
            mips_pipe_pkg::OP_RTYPE: begin
                regwrite = 1'b1;
                case (funct)
                    mips_pipe_pkg::FN_ADDU: alu_op = mips_pipe_pkg::ALU_ADD;
                    mips_pipe_pkg::FN_SUBU: alu_op = mips_pipe_pkg::ALU_SUB;
                    mips_pipe_pkg::FN_AND:  alu_op = mips_pipe_pkg::ALU_AND;
                    mips_pipe_pkg::FN_OR:   alu_op = mips_pipe_pkg::ALU_OR;
                    mips_pipe_pkg::FN_SLT:  alu_op = mips_pipe_pkg::ALU_SLT;
                    mips_pipe_pkg::FN_JR: begin
                        regwrite = 1'b0;
                        jtype    = mips_pipe_pkg::JT_REG;
                    end
                    default: regwrite = 1'b0; // unsupported funct, sll r0 nop included
                endcase
            end
            mips_pipe_pkg::OP_ADDIU: begin
                {use_imm, regwrite} = 2'b11;
                dest = rt;
            end
            mips_pipe_pkg::OP_LW: begin
                {use_imm, memread, regwrite} = 3'b111;
                dest = rt;
            end
            mips_pipe_pkg::OP_SW:  {use_imm, memwrite} = 2'b11;
            mips_pipe_pkg::OP_BEQ: jtype = mips_pipe_pkg::JT_CMP;
            mips_pipe_pkg::OP_BNE: begin
                jtype  = mips_pipe_pkg::JT_CMP;
                is_bne = 1'b1;
            end
            mips_pipe_pkg::OP_J: is_j = 1'b1;
            default: ;
        endcase
    end

    // register 0 stays zero, a write in the same cycle is seen by the read
    assign wb_we  = wb.valid && wb.regwrite && (wb.rd != '0);
    assign rs_val = (rs == '0) ? '0 : (wb_we && wb.rd == rs) ? wb.result : rf[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_we && wb.rd == rt) ? wb.result : rf[rt];

    always_ff @(posedge i_clk) begin
        if (wb_we) rf[wb.rd] <= wb.result;
    end

    hazard_detection_unit u_hazard_detection_unit (
        .i_memread_ex   (idex.memread),   // cleared on bubbles, so no valid needed
        .i_rt_ex        (idex.rd),
        .i_rs_id        (rs),
        .i_rt_id        (rt),
        .i_jumptype     (valid ? jtype : mips_pipe_pkg::JT_NONE),
        .i_rd_ex        (i_ex_rd),
        .i_rd_mem       (i_mem_rd),
        .i_regwrite_ex  (i_ex_regwrite),
        .i_regwrite_mem (i_mem_regwrite),
        .o_stall        (o_stall)
    );

    assign cmp_hit   = (rs_val == rt_val) ^ is_bne; // taken condition for beq or bne
    assign br_target = i_if_pc4 + {simm[29:0], 2'b00};
    assign j_target  = {i_if_pc4[31:28], i_if_instr[25:0], 2'b00};
    assign o_take    = valid && !o_stall && (is_j || (jtype == mips_pipe_pkg::JT_REG) ||
                       ((jtype == mips_pipe_pkg::JT_CMP) && cmp_hit));
    assign o_target  = is_j ? j_target :
                       (jtype == mips_pipe_pkg::JT_REG) ? rs_val : br_target;

    // a stalled or squashed slot goes out as a bubble
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            {idex.valid, idex.memread, idex.memwrite, idex.regwrite} <= '0;
        end else begin
            idex.valid    <= valid && !o_stall;
            idex.memread  <= valid && !o_stall && memread;
            idex.memwrite <= valid && !o_stall && memwrite;
            idex.regwrite <= valid && !o_stall && regwrite;
        end
    end

    always_ff @(posedge i_clk) begin
        idex.alu_op  <= alu_op;
        idex.rs_val  <= rs_val;
        idex.rt_val  <= rt_val;
        idex.rs      <= rs;
        idex.rt      <= rt;
        idex.imm     <= simm;
        idex.use_imm <= use_imm;
        idex.rd      <= dest;
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    id_ex_if.sink                    idex,
    mem_wb_if.sink                   wb,
    ex_mem_if.source                 exmem,
    output mips_pipe_pkg::reg_addr_t o_ex_rd,       // for the hazard unit in decode
    output logic                     o_ex_regwrite
);

    mips_pipe_pkg::word_t op_a, rt_fwd, op_b, alu_y;

    // newest producer wins, a load still in memory never forwards its address
    function automatic mips_pipe_pkg::word_t fwd(input mips_pipe_pkg::reg_addr_t r,
                                                 input mips_pipe_pkg::word_t dec_val);
        mips_pipe_pkg::word_t v;
        v = dec_val;
        if (r != '0 && wb.valid && wb.regwrite && wb.rd == r) v = wb.result;
        if (r != '0 && exmem.valid && exmem.regwrite && !exmem.memread && exmem.rd == r)
            v = exmem.alu_result;
        return v;
    endfunction

    always_comb begin
        op_a   = fwd(idex.rs, idex.rs_val);
        rt_fwd = fwd(idex.rt, idex.rt_val); // also the store data of sw
        op_b   = idex.use_imm ? idex.imm : rt_fwd;
        case (idex.alu_op)
            mips_pipe_pkg::ALU_SUB: alu_y = op_a - op_b;
            mips_pipe_pkg::ALU_AND: alu_y = op_a & op_b;
            mips_pipe_pkg::ALU_OR:  alu_y = op_a | op_b;
            mips_pipe_pkg::ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
            default:                alu_y = op_a + op_b;
        endcase
    end

    assign o_ex_rd       = idex.rd;
    assign o_ex_regwrite = idex.valid && idex.regwrite;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            {exmem.valid, exmem.memread, exmem.memwrite, exmem.regwrite} <= '0;
        end else begin
            exmem.valid    <= idex.valid;
            exmem.memread  <= idex.memread;
            exmem.memwrite <= idex.memwrite;
            exmem.regwrite <= idex.regwrite;
        end
    end

    always_ff @(posedge i_clk) begin
        exmem.alu_result <= alu_y;
        exmem.store_data <= rt_fwd;
        exmem.rd         <= idex.rd;
    end

    // decode gives each opcode at most one memory control
    a_one_mem_op : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(idex.memread && idex.memwrite));

endmodule

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage #(
    parameter int DMEM_ADDR_W = 6 // word address width of the data memory
) (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    ex_mem_if.sink                   exmem,
    mem_wb_if.source                 memwb,
    output mips_pipe_pkg::reg_addr_t o_mem_rd,      // for the hazard unit in decode
    output logic                     o_mem_regwrite
);

    mips_pipe_pkg::word_t   dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] waddr;  // byte address dropped to a word index
    mips_pipe_pkg::word_t   load_data;

    assign waddr     = exmem.alu_result[DMEM_ADDR_W+1:2];
    assign load_data = dmem[waddr]; // asynchronous read, lands in write-back next edge

    always_ff @(posedge i_clk) begin
        if (exmem.valid && exmem.memwrite) dmem[waddr] <= exmem.store_data;
    end

    assign o_mem_rd       = exmem.rd;
    assign o_mem_regwrite = exmem.valid && exmem.regwrite;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            memwb.valid    <= 1'b0;
            memwb.regwrite <= 1'b0;
        end else begin
            memwb.valid    <= exmem.valid;
            memwb.regwrite <= exmem.regwrite;
        end
    end

    always_ff @(posedge i_clk) begin
        memwb.rd     <= exmem.rd;
        memwb.result <= exmem.memread ? load_data : exmem.alu_result;
    end

    // the program must keep its data inside the memory, no aliasing of high addresses
    a_addr_in_range : assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (exmem.valid && (exmem.memread || exmem.memwrite)) |->
        (exmem.alu_result[31:DMEM_ADDR_W+2] == '0));

endmodule

`default_nettype wire

//--- mips_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_pipe_top #(
    parameter int DMEM_ADDR_W = 6
) (
    input  wire                      i_clk,
    input  wire                      i_arst_n,
    input  mips_pipe_pkg::word_t     i_instr,       // instruction at o_pc, same cycle
    output mips_pipe_pkg::word_t     o_pc,
    output logic                     o_retire_en,   // a register write is committed
    output mips_pipe_pkg::reg_addr_t o_retire_rd,
    output mips_pipe_pkg::word_t     o_retire_data,
    output logic                     o_stall
);

    mips_pipe_pkg::word_t     if_instr, if_pc4, target;
    mips_pipe_pkg::reg_addr_t ex_rd, mem_rd;
    logic                     if_squash, take, ex_regwrite, mem_regwrite;

    id_ex_if  idex_bus ();
    ex_mem_if exmem_bus ();
    mem_wb_if memwb_bus ();

    fetch_stage u_fetch_stage (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_stall     (o_stall),
        .i_take      (take),
        .i_target    (target),
        .i_instr     (i_instr),
        .o_pc        (o_pc),
        .o_if_instr  (if_instr),
        .o_if_pc4    (if_pc4),
        .o_if_squash (if_squash)
    );

    decode_stage u_decode_stage (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_if_instr     (if_instr),
        .i_if_pc4       (if_pc4),
        .i_if_squash    (if_squash),
        .i_ex_rd        (ex_rd),
        .i_ex_regwrite  (ex_regwrite),
        .i_mem_rd       (mem_rd),
        .i_mem_regwrite (mem_regwrite),
        .wb             (memwb_bus.sink),
        .idex           (idex_bus.source),
        .o_stall        (o_stall),
        .o_take         (take),
        .o_target       (target)
    );

    execute_stage u_execute_stage (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .idex          (idex_bus.sink),
        .wb            (memwb_bus.sink),
        .exmem         (exmem_bus.source),
        .o_ex_rd       (ex_rd),
        .o_ex_regwrite (ex_regwrite)
    );

    memory_stage #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_memory_stage (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .exmem          (exmem_bus.sink),
        .memwb          (memwb_bus.source),
        .o_mem_rd       (mem_rd),
        .o_mem_regwrite (mem_regwrite)
    );

    // writes to register 0 happen but are never reported
    assign o_retire_en   = memwb_bus.valid && memwb_bus.regwrite && (memwb_bus.rd != '0);
    assign o_retire_rd   = memwb_bus.rd;
    assign o_retire_data = memwb_bus.result;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int CLK_PERIOD = 100, // ns
    parameter int RST_CYCLES = 5,
    parameter int DRIVE_DLY  = 1    // inputs change this long after the rising edge
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
    end

    // reset is held from time 0 and let go just after a rising edge
    initial begin
        o_arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #(DRIVE_DLY);
        o_arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_mips_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_pipe;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 5;
    localparam int DRIVE_DLY   = 1;
    localparam int DMEM_ADDR_W = 6;
    localparam int ROM_DEPTH   = 64;

    // MIPS encodings of the supported subset
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [31:0] NOP     = 32'h0000_0000; // sll r0, r0, 0

    // marks on expected retire events around the load-use pair
    localparam logic [1:0] FLAG_NONE  = 2'd0;
    localparam logic [1:0] FLAG_SNAP  = 2'd1; // remember the stall count here
    localparam logic [1:0] FLAG_STALL = 2'd2; // a stall must have happened since the snap

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retire_en;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        stall;

    logic [31:0] prog [$];     // program words in address order
    logic [4:0]  exp_rd [$];   // expected retire events, in order
    logic [31:0] exp_val [$];
    logic [1:0]  exp_flag [$];
    logic [31:0] rom [ROM_DEPTH];
    logic [31:0] regs [32];    // architectural register model
    logic [31:0] dmem_model [64];
    logic [31:0] rng;
    logic [1:0]  next_flag;
    logic        built;
    int          prog_len;

    tb_clock_gen #(
        .CLK_PERIOD (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES),
        .DRIVE_DLY  (DRIVE_DLY)
    ) u_tb_clock_gen (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    mips_pipe_top #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) u_mips_pipe_top (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_instr       (instr),
        .o_pc          (pc),
        .o_retire_en   (retire_en),
        .o_retire_rd   (retire_rd),
        .o_retire_data (retire_data),
        .o_stall       (stall)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run("the DUT output differs from the architectural result");
        end
    endtask

    task automatic emit_word(input logic [31:0] w);
        prog.push_back(w);
    endtask

    // register 0 is never reported, so its writes leave no trace entry
    task automatic note_write(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) begin
            regs[rd] = v;
            exp_rd.push_back(rd);
            exp_val.push_back(v);
            exp_flag.push_back(next_flag);
        end
        next_flag = FLAG_NONE;
    endtask

    task automatic alu_rr(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        a = regs[rs];
        b = regs[rt];
        case (fn)
            FN_SUBU: v = a - b;
            FN_AND:  v = a & b;
            FN_OR:   v = a | b;
            FN_SLT:  v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: v = a + b;
        endcase
        emit_word({OP_RTYPE, rs, rt, rd, 5'd0, fn});
        note_write(rd, v);
    endtask

    task automatic alu_imm(input logic [4:0] rt, rs, input logic [15:0] imm);
        emit_word({OP_ADDIU, rs, rt, imm});
        note_write(rt, regs[rs] + sext16(imm));
    endtask

    task automatic store_word(input logic [4:0] rt, rs, input logic [15:0] imm);
        logic [31:0] addr;
        addr = regs[rs] + sext16(imm);
        dmem_model[addr[7:2]] = regs[rt];
        emit_word({OP_SW, rs, rt, imm});
    endtask

    task automatic load_word(input logic [4:0] rt, rs, input logic [15:0] imm);
        logic [31:0] addr;
        addr = regs[rs] + sext16(imm);
        emit_word({OP_LW, rs, rt, imm});
        note_write(rt, dmem_model[addr[7:2]]);
    endtask

    // words that must never retire write r31 with a value that no entry expects
    task automatic poison_slots(input int n);
        for (int i = 0; i < n; i++) emit_word({OP_ADDIU, 5'd0, 5'd31, 16'hdead});
    endtask

    task automatic branch_cmp(input logic is_bne, input logic [4:0] rs, rt, input int nskip);
        logic taken;
        taken = (regs[rs] == regs[rt]) != is_bne;
        emit_word({is_bne ? OP_BNE : OP_BEQ, rs, rt, 16'(nskip)});
        if (taken) poison_slots(nskip); // not taken falls through to the next real word
    endtask

    task automatic jump_abs(input int nskip);
        int target;
        target = prog.size() + 1 + nskip; // word index of the landing instruction
        emit_word({OP_J, 26'(target)});
        poison_slots(nskip);
    endtask

    task automatic jump_reg(input logic [4:0] rs, input int nskip);
        int target;
        target = prog.size() + 2 + nskip;
        alu_imm(rs, 5'd0, 16'(4 * target)); // address made right before jr, so jr stalls
        emit_word({OP_RTYPE, rs, 5'd0, 5'd0, 5'd0, FN_JR});
        poison_slots(nskip);
    endtask

    task automatic build_program();
        // each result of the dependent chain feeds the next from memory or write-back
        rng = xorshift32(rng);
        alu_imm(5'd1, 5'd0, rng[15:0]);
        rng = xorshift32(rng);
        alu_imm(5'd2, 5'd1, rng[31:16]);
        alu_rr(FN_ADDU, 5'd3, 5'd2, 5'd1);
        alu_rr(FN_SUBU, 5'd4, 5'd3, 5'd2);
        alu_rr(FN_AND, 5'd5, 5'd4, 5'd3);
        alu_rr(FN_OR, 5'd6, 5'd5, 5'd4);
        alu_rr(FN_SLT, 5'd7, 5'd6, 5'd3);
        alu_rr(FN_SLT, 5'd8, 5'd3, 5'd6);
        alu_rr(FN_ADDU, 5'd9, 5'd7, 5'd8);
        rng = xorshift32(rng);
        alu_imm(5'd0, 5'd1, rng[15:0]);    // lands in r0 and must vanish
        alu_rr(FN_ADDU, 5'd10, 5'd0, 5'd2); // r0 still reads as zero

        // store then load at one random word, then a use right behind the load
        rng = xorshift32(rng);
        alu_imm(5'd11, 5'd0, {9'd0, rng[6:2], 2'b00});
        rng = xorshift32(rng);
        next_flag = FLAG_SNAP;
        alu_imm(5'd12, 5'd0, rng[15:0]);
        store_word(5'd12, 5'd11, 16'd0);
        load_word(5'd13, 5'd11, 16'd0);
        next_flag = FLAG_STALL;
        alu_rr(FN_ADDU, 5'd14, 5'd13, 5'd13);
        store_word(5'd14, 5'd11, 16'd4);
        load_word(5'd15, 5'd11, 16'd4);

        // branches whose operands come from the instruction just before
        rng = xorshift32(rng);
        alu_imm(5'd16, 5'd0, rng[15:0]);
        alu_imm(5'd17, 5'd16, 16'd0);
        branch_cmp(1'b0, 5'd16, 5'd17, 2); // beq taken over two words
        alu_imm(5'd18, 5'd16, 16'd1);
        branch_cmp(1'b1, 5'd18, 5'd16, 1); // bne taken
        branch_cmp(1'b0, 5'd18, 5'd16, 1); // beq not taken
        alu_imm(5'd19, 5'd18, 16'd2);
        branch_cmp(1'b1, 5'd19, 5'd19, 1); // bne not taken
        alu_imm(5'd20, 5'd19, 16'd3);
        load_word(5'd21, 5'd11, 16'd0);
        branch_cmp(1'b0, 5'd21, 5'd12, 1); // load feeding a branch, taken
        alu_rr(FN_OR, 5'd22, 5'd21, 5'd20);

        // absolute and register jumps
        jump_abs(1);
        alu_rr(FN_SUBU, 5'd23, 5'd22, 5'd1);
        jump_reg(5'd24, 2);
        alu_imm(5'd25, 5'd24, 16'd1);
        alu_rr(FN_SLT, 5'd26, 5'd25, 5'd23);
    endtask

    initial begin : program_setup
        built     = 1'b0;
        rng       = 32'd21370;
        next_flag = FLAG_NONE;
        for (int i = 0; i < 32; i++) regs[i] = 32'd0;
        for (int i = 0; i < 64; i++) dmem_model[i] = 32'd0;
        build_program();
        prog_len = prog.size();
        if (prog_len > ROM_DEPTH) abort_run("program does not fit the instruction ROM");
        for (int i = 0; i < ROM_DEPTH; i++) rom[i] = (i < prog_len) ? prog[i] : NOP;
        built = 1'b1;
    end

    // the instruction ROM answers for the pc that the last edge produced
    initial begin : instr_drive
        instr = NOP;
        forever begin
            @(posedge clk);
            #(DRIVE_DLY);
            instr = (pc[31:8] == '0) ? rom[pc[7:2]] : NOP;
        end
    end

    initial begin : watchdog
        wait (built);
        #((2 * prog_len + 4 + RST_CYCLES) * CLK_PERIOD);
        abort_run("watchdog expired before the retire trace was complete");
    end

    // outputs are sampled on the falling edge, half a period away from any change
    initial begin : retire_check
        int idx;
        int stall_cnt;
        int stall_base;
        idx        = 0;
        stall_cnt  = 0;
        stall_base = 0;
        wait (built);
        @(posedge clk);
        @(negedge clk);
        check_value("o_pc", pc, 32'd0); // still in reset here
        check_value("o_retire_en", {31'd0, retire_en}, 32'd0);
        check_value("o_stall", {31'd0, stall}, 32'd0);
        wait (arst_n);
        while (idx < exp_rd.size()) begin
            @(negedge clk);
            if (retire_en) begin
                check_value($sformatf("o_retire_rd (event %0d)", idx),
                            {27'd0, retire_rd}, {27'd0, exp_rd[idx]});
                check_value($sformatf("o_retire_data (event %0d)", idx),
                            retire_data, exp_val[idx]);
                if (exp_flag[idx] == FLAG_SNAP) stall_base = stall_cnt;
                if ((exp_flag[idx] == FLAG_STALL) && (stall_cnt == stall_base)) begin
                    abort_run("the load and its direct use went through without a stall");
                end
                idx++;
            end
            if (stall) stall_cnt++; // counted after the snap of the same cycle
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- mips_pipe.f
mips_pipe_pkg.sv
mips_pipe_if.sv
fetch_stage.sv
hazard_detection_unit.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
mips_pipe_top.sv
tb_clock_gen.sv
tb_mips_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# the exit status is the simulator's own, nonzero on any failure

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mips_pipe \
    -f mips_pipe.f \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_mips_pipe
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

exit 0
